// File: mipsCore_params.svh
// global widths and constants for the single-cycle MIPS core
// include wherever a width, the reset vector or the link register is needed
`ifndef MIPS_CORE_PARAMS_SVH
`define MIPS_CORE_PARAMS_SVH

// data word and instruction address width
`define MIPS_XLEN 32

// register index width, 32 architectural registers
`define MIPS_REG_AW 5

// data memory word address, 128 words
`define MIPS_DMEM_AW 7

// first fetch after reset
`define MIPS_RESET_PC 0

// jal writes its return address here
`define MIPS_LINK_REG 31

`endif

// File: isaPkg.sv
// instruction set definitions for the MIPS32 subset
// field types plus opcode and funct encodings, shared by RTL and testbench
`include "mipsCore_params.svh"

package isaPkg;

  // ==================================================
  // field types
  // ==================================================
  // data word, also used for instruction and data addresses
  typedef logic [`MIPS_XLEN-1:0] wordT;
  // register index from rs, rt or rd
  typedef logic [`MIPS_REG_AW-1:0] regAddrT;
  // bits 31..26 of every instruction
  typedef logic [5:0] opcodeT;
  // bits 5..0 of an R-type instruction
  typedef logic [5:0] functT;
  // I-type immediate, sign extended in the datapath
  typedef logic [15:0] imm16T;
  // J-type word index
  typedef logic [25:0] jumpIdxT;

  // ==================================================
  // opcodes
  // ==================================================
  localparam opcodeT OP_RTYPE = 6'b000000;
  localparam opcodeT OP_J     = 6'b000010;
  localparam opcodeT OP_JAL   = 6'b000011;
  localparam opcodeT OP_BEQ   = 6'b000100;
  localparam opcodeT OP_LW    = 6'b100011;
  localparam opcodeT OP_SW    = 6'b101011;

  // ==================================================
  // R-type funct codes
  // ==================================================
  localparam functT FN_ADD = 6'b100000;
  localparam functT FN_SUB = 6'b100010;
  localparam functT FN_AND = 6'b100100;
  localparam functT FN_OR  = 6'b100101;
  // signed compare
  localparam functT FN_SLT = 6'b101010;

endpackage

// File: ctrlPkg.sv
// control encodings between the decoders and the execute unit
// holds the ALU operation class and the ALU function code
package ctrlPkg;

  // ==================================================
  // operation class from the main decoder
  // ==================================================
  typedef logic [1:0] aluOpT;

  // lw and sw compute base + offset
  localparam aluOpT ALUOP_MEM    = 2'b00;
  // beq compares by subtraction
  localparam aluOpT ALUOP_BRANCH = 2'b01;
  // R-type, funct picks the operation
  localparam aluOpT ALUOP_RTYPE  = 2'b10;

  // ==================================================
  // ALU function code
  // ==================================================
  typedef logic [3:0] aluFnT;

  localparam aluFnT ALU_AND  = 4'b0000;
  localparam aluFnT ALU_OR   = 4'b0001;
  localparam aluFnT ALU_ADD  = 4'b0010;
  localparam aluFnT ALU_SUB  = 4'b0110;
  localparam aluFnT ALU_SLT  = 4'b0111;
  // unknown funct, result forced to zero
  localparam aluFnT ALU_NONE = 4'b1111;

endpackage

// File: mainDecoder.sv
// main control decoder of the single-cycle core
// turns the opcode into datapath levels and the active-low SRAM enables
module mainDecoder (
  input  logic           rst,
  input  isaPkg::opcodeT opcode,
  output logic           regDst,
  output logic           aluSrc,
  output logic           memToReg,
  output logic           regWrite,
  output logic           branch,
  output logic           jump,
  output logic           link,
  output ctrlPkg::aluOpT aluOp,
  output logic           cen,
  output logic           wen
);

  // raw decode before reset qualification
  logic memRead;
  logic memWrite;
  logic regWriteDec;

  always_comb begin
    // defaults give a no-op, so unknown opcodes write nothing
    regDst      = 1'b0;
    aluSrc      = 1'b0;
    memToReg    = 1'b0;
    regWriteDec = 1'b0;
    memRead     = 1'b0;
    memWrite    = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    link        = 1'b0;
    aluOp       = ctrlPkg::ALUOP_MEM;
    case (opcode)
      isaPkg::OP_RTYPE: begin
        regDst      = 1'b1;
        regWriteDec = 1'b1;
        aluOp       = ctrlPkg::ALUOP_RTYPE;
      end
      isaPkg::OP_LW: begin
        aluSrc      = 1'b1;
        memToReg    = 1'b1;
        regWriteDec = 1'b1;
        memRead     = 1'b1;
      end
      isaPkg::OP_SW: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
      end
      isaPkg::OP_BEQ: begin
        branch = 1'b1;
        aluOp  = ctrlPkg::ALUOP_BRANCH;
      end
      isaPkg::OP_J: begin
        jump = 1'b1;
      end
      isaPkg::OP_JAL: begin
        // return address goes to r31
        jump        = 1'b1;
        link        = 1'b1;
        regWriteDec = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // no register or memory activity while rst is low
  assign regWrite = rst & regWriteDec;
  // chip enable low for any access, write enable low only for sw
  assign cen = ~(rst & (memRead | memWrite));
  assign wen = ~(rst & memWrite);

endmodule

// File: aluDecoder.sv
// ALU control decoder
// combines the operation class from the main decoder with the funct field
module aluDecoder (
  input  ctrlPkg::aluOpT aluOp,
  input  isaPkg::functT  funct,
  output ctrlPkg::aluFnT aluFn
);

  // R-type funct lookup
  ctrlPkg::aluFnT rtypeFn;

  always_comb begin
    case (funct)
      isaPkg::FN_ADD: rtypeFn = ctrlPkg::ALU_ADD;
      isaPkg::FN_SUB: rtypeFn = ctrlPkg::ALU_SUB;
      isaPkg::FN_AND: rtypeFn = ctrlPkg::ALU_AND;
      isaPkg::FN_OR:  rtypeFn = ctrlPkg::ALU_OR;
      isaPkg::FN_SLT: rtypeFn = ctrlPkg::ALU_SLT;
      // jr, shifts and the rest are not built
      default:        rtypeFn = ctrlPkg::ALU_NONE;
    endcase
  end

  // ==================================================
  // class select
  // ==================================================
  always_comb begin
    case (aluOp)
      // address arithmetic for lw and sw
      ctrlPkg::ALUOP_MEM:    aluFn = ctrlPkg::ALU_ADD;
      // beq equality via subtraction
      ctrlPkg::ALUOP_BRANCH: aluFn = ctrlPkg::ALU_SUB;
      ctrlPkg::ALUOP_RTYPE:  aluFn = rtypeFn;
      default:               aluFn = ctrlPkg::ALU_NONE;
    endcase
  end

endmodule

// File: executeUnit.sv
// execute stage of the single-cycle core
// sign extension, second operand select, ALU and zero flag
// immExt is also handed to the PC unit for branch targets
`include "mipsCore_params.svh"

module executeUnit (
  input  isaPkg::wordT   rsData,
  input  isaPkg::wordT   rtData,
  input  isaPkg::imm16T  imm,
  input  logic           aluSrc,
  input  ctrlPkg::aluFnT aluFn,
  output isaPkg::wordT   aluResult,
  output logic           zero,
  output isaPkg::wordT   immExt
);

  // second ALU operand
  isaPkg::wordT opB;
  // signed view of the operands for slt
  logic signed [`MIPS_XLEN-1:0] opASigned;
  logic signed [`MIPS_XLEN-1:0] opBSigned;

  // ==================================================
  // operand preparation
  // ==================================================
  // replicate bit 15 into the upper half
  assign immExt = {{(`MIPS_XLEN - 16){imm[15]}}, imm};

  // immediate for lw/sw, register for R-type and beq
  assign opB = aluSrc ? immExt : rtData;

  assign opASigned = rsData;
  assign opBSigned = opB;

  // ==================================================
  // ALU
  // ==================================================
  always_comb begin
    case (aluFn)
      ctrlPkg::ALU_AND: aluResult = rsData & opB;
      ctrlPkg::ALU_OR:  aluResult = rsData | opB;
      ctrlPkg::ALU_ADD: aluResult = rsData + opB;
      ctrlPkg::ALU_SUB: aluResult = rsData - opB;
      ctrlPkg::ALU_SLT: begin
        // 1 when rs < operand, two's complement
        aluResult = {{(`MIPS_XLEN - 1){1'b0}}, (opASigned < opBSigned)};
      end
      // unknown function reads as zero
      default:          aluResult = '0;
    endcase
  end

  // beq takes the branch when rs - rt is zero
  assign zero = (aluResult == '0);

endmodule

// File: regFile.sv
// general register file of the single-cycle core
// r1..r31 in flops, r0 hardwired to zero, two combinational read ports
// also picks the destination index and the write-back value
`include "mipsCore_params.svh"

module regFile (
  input  logic            clk,
  input  logic            rst,
  input  isaPkg::regAddrT rsAddr,
  input  isaPkg::regAddrT rtAddr,
  input  isaPkg::regAddrT rdAddr,
  input  logic            regDst,
  input  logic            link,
  input  logic            memToReg,
  input  logic            regWrite,
  input  isaPkg::wordT    aluResult,
  input  isaPkg::wordT    loadData,
  input  isaPkg::wordT    linkAddr,
  output isaPkg::wordT    rsData,
  output isaPkg::wordT    rtData,
  output isaPkg::wordT    writeData
);

  // storage for r1..r31
  isaPkg::wordT    regs [1:`MIPS_LINK_REG];
  // selected destination
  isaPkg::regAddrT wrAddr;

  // ==================================================
  // write-back selection
  // ==================================================
  // jal -> r31, R-type -> rd, lw -> rt
  assign wrAddr = link   ? isaPkg::regAddrT'(`MIPS_LINK_REG) :
                  regDst ? rdAddr : rtAddr;

  // link address wins, then load data, else ALU
  assign writeData = link     ? linkAddr :
                     memToReg ? loadData : aluResult;

  // ==================================================
  // register array
  // ==================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 1; i <= `MIPS_LINK_REG; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite && (wrAddr != '0)) begin
      // writes to r0 are dropped
      regs[wrAddr] <= writeData;
    end
  end

  // read ports, r0 always zero
  assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
  assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

// File: pcUnit.sv
// program counter and next-address logic
// priority is jump, then taken branch, then PC+4
// linkAddr (PC+8) is the jal return value
`include "mipsCore_params.svh"

module pcUnit (
  input  logic            clk,
  input  logic            rst,
  input  logic            jump,
  input  logic            branch,
  input  logic            zero,
  input  isaPkg::wordT    immExt,
  input  isaPkg::jumpIdxT jumpIdx,
  output isaPkg::wordT    pc,
  output isaPkg::wordT    linkAddr
);

  // current fetch address
  isaPkg::wordT pcReg;
  isaPkg::wordT pcPlus4;
  isaPkg::wordT branchTarget;
  isaPkg::wordT jumpTarget;
  isaPkg::wordT pcNext;
  logic         branchTaken;

  // ==================================================
  // candidate addresses
  // ==================================================
  assign pcPlus4  = pcReg + 32'd4;
  assign linkAddr = pcReg + 32'd8;

  // word offset relative to the delay-slot address
  assign branchTarget = pcPlus4 + {immExt[`MIPS_XLEN-3:0], 2'b00};

  // region bits from PC+4, index scaled to bytes
  assign jumpTarget = {pcPlus4[`MIPS_XLEN-1:28], jumpIdx, 2'b00};

  assign branchTaken = branch & zero;

  always_comb begin
    if (jump) begin
      pcNext = jumpTarget;
    end else if (branchTaken) begin
      pcNext = branchTarget;
    end else begin
      pcNext = pcPlus4;
    end
  end

  // ==================================================
  // PC register
  // ==================================================
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pcReg <= isaPkg::wordT'(`MIPS_RESET_PC);
    end else begin
      pcReg <= pcNext;
    end
  end

  assign pc = pcReg;

endmodule

// File: mipsCore.sv
// top level of the single-cycle MIPS core
// combinational instruction port plus an async SRAM-style data port
// regWriteData shows the register write-back value each cycle
`include "mipsCore_params.svh"

module mipsCore (
  input  logic                     clk,
  input  logic                     rst,
  // instruction fetch
  output isaPkg::wordT             instrAddr,
  input  isaPkg::wordT             instr,
  // data SRAM, enables active low
  output logic                     cen,
  output logic                     wen,
  output logic [`MIPS_DMEM_AW-1:0] addr,
  output isaPkg::wordT             storeData,
  input  isaPkg::wordT             loadData,
  // observation
  output isaPkg::wordT             regWriteData
);

  // ==================================================
  // instruction fields
  // ==================================================
  isaPkg::opcodeT  opcode;
  isaPkg::functT   funct;
  isaPkg::regAddrT rsAddr;
  isaPkg::regAddrT rtAddr;
  isaPkg::regAddrT rdAddr;
  isaPkg::imm16T   imm;
  isaPkg::jumpIdxT jumpIdx;

  assign opcode  = instr[31:26];
  assign rsAddr  = instr[25:21];
  assign rtAddr  = instr[20:16];
  assign rdAddr  = instr[15:11];
  assign funct   = instr[5:0];
  assign imm     = instr[15:0];
  assign jumpIdx = instr[25:0];

  // control levels
  logic regDst;
  logic aluSrc;
  logic memToReg;
  logic regWrite;
  logic branch;
  logic jump;
  logic link;
  ctrlPkg::aluOpT aluOp;
  ctrlPkg::aluFnT aluFn;

  // datapath
  isaPkg::wordT rsData;
  isaPkg::wordT rtData;
  isaPkg::wordT aluResult;
  isaPkg::wordT immExt;
  isaPkg::wordT linkAddr;
  logic         zero;

  mainDecoder i_mainDecoder (
    .rst      (rst),
    .opcode   (opcode),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .memToReg (memToReg),
    .regWrite (regWrite),
    .branch   (branch),
    .jump     (jump),
    .link     (link),
    .aluOp    (aluOp),
    .cen      (cen),
    .wen      (wen)
  );

  aluDecoder i_aluDecoder (.aluOp(aluOp), .funct(funct), .aluFn(aluFn));

  executeUnit i_executeUnit (
    .rsData    (rsData),
    .rtData    (rtData),
    .imm       (imm),
    .aluSrc    (aluSrc),
    .aluFn     (aluFn),
    .aluResult (aluResult),
    .zero      (zero),
    .immExt    (immExt)
  );

  regFile i_regFile (
    .clk       (clk),
    .rst       (rst),
    .rsAddr    (rsAddr),
    .rtAddr    (rtAddr),
    .rdAddr    (rdAddr),
    .regDst    (regDst),
    .link      (link),
    .memToReg  (memToReg),
    .regWrite  (regWrite),
    .aluResult (aluResult),
    .loadData  (loadData),
    .linkAddr  (linkAddr),
    .rsData    (rsData),
    .rtData    (rtData),
    .writeData (regWriteData)
  );

  pcUnit i_pcUnit (
    .clk      (clk),
    .rst      (rst),
    .jump     (jump),
    .branch   (branch),
    .zero     (zero),
    .immExt   (immExt),
    .jumpIdx  (jumpIdx),
    .pc       (instrAddr),
    .linkAddr (linkAddr)
  );

  // ==================================================
  // data port
  // ==================================================
  // byte address to word address
  assign addr      = aluResult[`MIPS_DMEM_AW+1:2];
  assign storeData = rtData;

endmodule

// File: tbMipsCore.sv
// testbench for the single-cycle MIPS core
// models the instruction ROM and data SRAM, runs directed test tasks
// stops at the first mismatch, a watchdog bounds the run time
`include "mipsCore_params.svh"

module tbMipsCore;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 5;
  localparam int RESET_CYCLES = 4;
  // longest program in cycles
  localparam int MAX_PROG_CYCLES = 12;
  localparam int MARGIN_CYCLES = 40;
  localparam int WATCHDOG_NS =
    (NUM_TESTS * (RESET_CYCLES + MAX_PROG_CYCLES) + MARGIN_CYCLES) * 20;

  logic                     clk;
  logic                     rst;
  isaPkg::wordT             instrAddr;
  isaPkg::wordT             instr;
  logic                     cen;
  logic                     wen;
  logic [`MIPS_DMEM_AW-1:0] addr;
  isaPkg::wordT             storeData;
  isaPkg::wordT             loadData;
  isaPkg::wordT             regWriteData;

  // 64-word instruction ROM and 128-word data SRAM
  isaPkg::wordT rom [0:63];
  isaPkg::wordT sram [0:(1 << `MIPS_DMEM_AW) - 1];
  integer       seed;

  mipsCore i_mipsCore (
    .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
    .cen(cen), .wen(wen), .addr(addr), .storeData(storeData),
    .loadData(loadData), .regWriteData(regWriteData)
  );

  always #10 clk = ~clk;

  // ==================================================
  // memory models
  // ==================================================
  assign instr    = rom[instrAddr[7:2]];
  assign loadData = sram[addr];

  // write needs both enables low
  always @(posedge clk) begin
    if (!cen && !wen) begin
      sram[addr] <= storeData;
    end
  end

  // ==================================================
  // helpers
  // ==================================================
  function automatic isaPkg::wordT encodeR(input isaPkg::regAddrT rs, input isaPkg::regAddrT rt,
                                          input isaPkg::regAddrT rd, input isaPkg::functT fn);
    return {isaPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic isaPkg::wordT encodeI(input isaPkg::opcodeT op, input isaPkg::regAddrT rs,
                                          input isaPkg::regAddrT rt, input isaPkg::imm16T imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic expectEqual(input string testName, input string what,
                             input isaPkg::wordT expected, input isaPkg::wordT actual);
    assert (actual === expected) else begin
      $display("MISMATCH %s: %s expected %h actual %h", testName, what, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "stopped at first error");
    end
  endtask

  // both SRAM enables inactive
  task automatic expectIdle(input string testName);
    expectEqual(testName, "cen", 1'b1, cen);
    expectEqual(testName, "wen", 1'b1, wen);
  endtask

  // reset asserted, memories reloaded at the following falling edge
  task automatic enterReset();
    int i;
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    for (i = 0; i < 64; i++) begin
      // all-zero word decodes as a no-op
      rom[i] = '0;
    end
    for (i = 0; i < (1 << `MIPS_DMEM_AW); i++) begin
      sram[i] = 32'ha5c3_0000 | (i << 8) | i;
    end
  endtask

  task automatic leaveReset(input string testName);
    expectIdle(testName);
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      expectIdle(testName);
    end
    @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    expectEqual(testName, "first instrAddr", 32'h0, instrAddr);
  endtask

  // check write-back, then move to the next instruction
  task automatic retire(input string testName, input string what,
                        input isaPkg::wordT expected);
    expectEqual(testName, what, expected, regWriteData);
    @(negedge clk);
  endtask

  // ==================================================
  // directed tests
  // ==================================================
  task automatic aluTest();
    string        name;
    isaPkg::wordT opA;
    isaPkg::wordT opB;
    isaPkg::wordT opNeg;
    name  = "alu";
    opA   = $random(seed) & 32'h7fff_ffff;
    opB   = $random(seed);
    opNeg = $random(seed) | 32'h8000_0000;
    enterReset();
    sram[0] = opA;
    sram[1] = opB;
    sram[2] = opNeg;
    rom[0] = encodeI(isaPkg::OP_LW, 5'd0, 5'd1, 16'h0000);
    rom[1] = encodeI(isaPkg::OP_LW, 5'd0, 5'd2, 16'h0004);
    rom[2] = encodeI(isaPkg::OP_LW, 5'd0, 5'd3, 16'h0008);
    rom[3] = encodeR(5'd1, 5'd2, 5'd4, isaPkg::FN_ADD);
    rom[4] = encodeR(5'd1, 5'd2, 5'd5, isaPkg::FN_SUB);
    rom[5] = encodeR(5'd1, 5'd2, 5'd6, isaPkg::FN_AND);
    rom[6] = encodeR(5'd1, 5'd2, 5'd7, isaPkg::FN_OR);
    rom[7] = encodeR(5'd3, 5'd1, 5'd8, isaPkg::FN_SLT);
    rom[8] = encodeR(5'd1, 5'd3, 5'd9, isaPkg::FN_SLT);
    rom[9] = encodeR(5'd1, 5'd2, 5'd10, isaPkg::FN_SLT);
    leaveReset(name);
    retire(name, "lw r1", opA);
    retire(name, "lw r2", opB);
    retire(name, "lw r3", opNeg);
    retire(name, "add", opA + opB);
    retire(name, "sub", opA - opB);
    retire(name, "and", opA & opB);
    retire(name, "or", opA | opB);
    // negative operand below a positive one
    retire(name, "slt neg", ($signed(opNeg) < $signed(opA)) ? 32'd1 : 32'd0);
    retire(name, "slt pos", ($signed(opA) < $signed(opNeg)) ? 32'd1 : 32'd0);
    retire(name, "slt rnd", ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0);
  endtask

  task automatic memTest();
    string        name;
    isaPkg::wordT data;
    isaPkg::wordT base;
    isaPkg::wordT byteAddr;
    name = "loadStore";
    data = $random(seed);
    // base in the upper half keeps the stored words clear of words 4 and 5
    base = ($random(seed) & 32'h0000_00fc) | 32'h0000_0100;
    enterReset();
    sram[4] = data;
    sram[5] = base;
    rom[0] = encodeI(isaPkg::OP_LW, 5'd0, 5'd1, 16'h0010);
    rom[1] = encodeI(isaPkg::OP_LW, 5'd0, 5'd2, 16'h0014);
    rom[2] = encodeI(isaPkg::OP_SW, 5'd2, 5'd1, 16'h0008);
    rom[3] = encodeI(isaPkg::OP_LW, 5'd2, 5'd3, 16'h0008);
    // negative offset
    rom[4] = encodeI(isaPkg::OP_SW, 5'd2, 5'd1, 16'hfffc);
    rom[5] = encodeI(isaPkg::OP_LW, 5'd2, 5'd4, 16'hfffc);
    leaveReset(name);
    retire(name, "lw data", data);
    retire(name, "lw base", base);
    for (int k = 0; k < 2; k++) begin
      byteAddr = (k == 0) ? base + 32'd8 : base - 32'd4;
      expectEqual(name, "sw cen", 1'b0, cen);
      expectEqual(name, "sw wen", 1'b0, wen);
      expectEqual(name, "sw addr", byteAddr[8:2], addr);
      expectEqual(name, "sw storeData", data, storeData);
      @(negedge clk);
      expectEqual(name, "lw cen", 1'b0, cen);
      expectEqual(name, "lw wen", 1'b1, wen);
      expectEqual(name, "lw addr", byteAddr[8:2], addr);
      retire(name, "lw stored word", data);
    end
  endtask

  task automatic branchTest();
    string        name;
    isaPkg::wordT val;
    name = "branch";
    val  = $random(seed);
    enterReset();
    sram[0] = val;
    sram[1] = val ^ 32'h1;
    rom[0] = encodeI(isaPkg::OP_LW, 5'd0, 5'd1, 16'h0000);
    rom[1] = encodeI(isaPkg::OP_LW, 5'd0, 5'd2, 16'h0000);
    rom[2] = encodeI(isaPkg::OP_LW, 5'd0, 5'd3, 16'h0004);
    rom[3] = encodeI(isaPkg::OP_BEQ, 5'd1, 5'd2, 16'd3);
    rom[7] = encodeI(isaPkg::OP_BEQ, 5'd1, 5'd3, 16'd5);
    rom[8] = encodeI(isaPkg::OP_BEQ, 5'd0, 5'd0, 16'hfffa);
    leaveReset(name);
    retire(name, "lw r1", val);
    retire(name, "lw r2", val);
    retire(name, "lw r3", val ^ 32'h1);
    // equal registers, taken forward
    expectIdle(name);
    @(negedge clk);
    expectEqual(name, "beq taken", 32'd12 + 32'd4 + 3 * 4, instrAddr);
    // unequal registers, falls through
    expectIdle(name);
    @(negedge clk);
    expectEqual(name, "beq not taken", 32'd28 + 32'd4, instrAddr);
    // taken backward
    expectIdle(name);
    @(negedge clk);
    expectEqual(name, "beq backward", 32'd32 + 32'd4 - 6 * 4, instrAddr);
  endtask

  task automatic jumpTest();
    string        name;
    isaPkg::wordT linkVal;
    name = "jump";
    enterReset();
    rom[0]  = {isaPkg::OP_J, 26'd5};
    rom[5]  = {isaPkg::OP_JAL, 26'd10};
    rom[10] = encodeR(5'd31, 5'd0, 5'd4, isaPkg::FN_ADD);
    leaveReset(name);
    @(negedge clk);
    expectEqual(name, "j target", ((32'd0 + 4) & 32'hf000_0000) | (32'd5 << 2), instrAddr);
    // jal sits at word 5
    linkVal = 32'd20 + 32'd8;
    retire(name, "jal link", linkVal);
    expectEqual(name, "jal target", ((32'd20 + 4) & 32'hf000_0000) | (32'd10 << 2), instrAddr);
    retire(name, "add from r31", linkVal);
  endtask

  task automatic zeroRegTest();
    string        name;
    isaPkg::wordT val;
    name = "zeroReg";
    val  = $random(seed) | 32'h1;
    enterReset();
    sram[0] = val;
    // sw first, so the enables in reset are meaningful
    rom[0] = encodeI(isaPkg::OP_SW, 5'd0, 5'd0, 16'h000c);
    rom[1] = encodeI(isaPkg::OP_LW, 5'd0, 5'd1, 16'h0000);
    rom[2] = encodeR(5'd1, 5'd1, 5'd0, isaPkg::FN_ADD);
    rom[3] = encodeR(5'd0, 5'd0, 5'd2, isaPkg::FN_ADD);
    rom[4] = encodeR(5'd0, 5'd1, 5'd3, isaPkg::FN_OR);
    leaveReset(name);
    expectEqual(name, "sw r0 data", 32'h0, storeData);
    @(negedge clk);
    retire(name, "lw r1", val);
    retire(name, "add to r0", val + val);
    retire(name, "read r0", 32'h0);
    retire(name, "or with r0", val);
  endtask

  // ==================================================
  // main sequence and watchdog
  // ==================================================
  initial begin
    clk  = 1'b0;
    rst  = 1'b0;
    seed = 32'h5e23_635e;
    for (int i = 0; i < 64; i++) begin
      rom[i] = '0;
    end
    for (int i = 0; i < (1 << `MIPS_DMEM_AW); i++) begin
      sram[i] = '0;
    end
    aluTest();
    memTest();
    branchTest();
    jumpTest();
    zeroRegTest();
    $display("PASS: all tests");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: simulation timed out after %0d ns", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: mipsCore.f
+incdir+.
isaPkg.sv
ctrlPkg.sv
mainDecoder.sv
aluDecoder.sv
executeUnit.sv
regFile.sv
pcUnit.sv
mipsCore.sv
tbMipsCore.sv
